//--- source/spi_pkg.sv
`default_nettype none

package spi_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Bits per SPI transfer
    localparam int SPI_WORD_LEN = 8;

    // Upper bound for the channel count of the array
    localparam int MAX_CHANNELS = 8;

    // Width of a channel select
    localparam int CHAN_IDX_W = 3;

    //////////////////////////////
    // Types
    //////////////////////////////

    // One SPI data word
    typedef logic [SPI_WORD_LEN-1:0] spi_word_t;

    // Prescaler exponent
    // Half sck period is 2**(value + 1) clock cycles
    typedef logic [2:0] presc_t;

    // SPI mode, bit 1 is CPOL and bit 0 is CPHA
    typedef logic [1:0] spi_mode_t;

    // Channel select
    typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

    // Channel FSM
    typedef enum logic {
        SPI_IDLE,
        SPI_SHIFT
    } spi_state_t;

endpackage

`default_nettype wire

//--- source/spi_channel.sv
`timescale 1ns/1ps
`default_nettype none

module spi_channel (
    input  logic               wr,
    input  logic               rst,
    input  logic               tx_valid,
    input  spi_pkg::spi_word_t tx_word,
    input  spi_pkg::presc_t    tx_presc,
    input  spi_pkg::spi_mode_t tx_mode,
    input  logic               tx_lsb_first,
    input  logic               miso,
    output logic               tx_take,
    output logic               rx_done,
    output spi_pkg::spi_word_t rx_word,
    output logic               sck,
    output logic               mosi,
    output logic               ss
);
    import spi_pkg::*;

    // Prescaler counter covers the longest half period, 2**8 cycles
    localparam int PCNT_W = 2 ** $bits(presc_t);
    // Counts the sck edges of one word
    localparam int EDGE_W = $clog2(2 * SPI_WORD_LEN);
    localparam logic [EDGE_W-1:0] LAST_EDGE = EDGE_W'(2 * SPI_WORD_LEN - 1);

    spi_state_t        state;
    spi_word_t         shift_out;
    spi_word_t         shift_in;
    presc_t            presc_q;
    spi_mode_t         mode_q;
    logic              lsb_q;
    logic [PCNT_W-1:0] presc_cnt;
    logic [PCNT_W-1:0] half_limit;
    logic [EDGE_W-1:0] edge_cnt;
    logic              sck_lvl;
    logic              mosi_q;
    logic              half_end;
    logic              last_edge;
    logic              sample_edge;
    logic              drive_edge;

    // Bit that goes out next for the given order
    function automatic logic lead_bit(input spi_word_t w, input logic lsb);
        if (lsb)
        begin
            return w[0];
        end
        return w[SPI_WORD_LEN-1];
    endfunction

    // Drops the bit just sent, fills with ones
    function automatic spi_word_t shift_word(input spi_word_t w, input logic lsb);
        if (lsb)
        begin
            return {1'b1, w[SPI_WORD_LEN-1:1]};
        end
        return {w[SPI_WORD_LEN-2:0], 1'b1};
    endfunction

    //////////////////////////////
    // Timing decode
    //////////////////////////////

    // Word handoff from the host port
    assign tx_take = (state == SPI_IDLE) && tx_valid;

    // Terminal count of one half period
    assign half_limit = PCNT_W'((1 << (int'(presc_q) + 1)) - 1);
    assign half_end   = (state == SPI_SHIFT) && (presc_cnt == half_limit);
    assign last_edge  = (edge_cnt == LAST_EDGE);

    // Even edges lead, odd edges trail
    // CPHA 0 samples on leading edges, CPHA 1 on trailing edges
    assign sample_edge = half_end && (edge_cnt[0] == mode_q[0]);
    // No new bit after the final edge
    assign drive_edge  = half_end && (edge_cnt[0] != mode_q[0]) && !last_edge;

    //////////////////////////////
    // Channel FSM
    //////////////////////////////

    always_ff @(posedge wr or posedge rst)
    begin
        if (rst)
        begin
            state     <= SPI_IDLE;
            ss        <= 1'b1;
            mosi_q    <= 1'b1;
            sck_lvl   <= 1'b0;
            mode_q    <= '0;
            presc_cnt <= '0;
            edge_cnt  <= '0;
            rx_done   <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            case (state)
                SPI_IDLE:
                begin
                    if (tx_take)
                    begin
                        state     <= SPI_SHIFT;
                        ss        <= 1'b0;
                        mode_q    <= tx_mode;
                        presc_cnt <= '0;
                        edge_cnt  <= '0;
                        sck_lvl   <= 1'b0;
                        // CPHA 0 needs the first bit before the first edge
                        if (!tx_mode[0])
                        begin
                            mosi_q <= lead_bit(tx_word, tx_lsb_first);
                        end
                    end
                end
                SPI_SHIFT:
                begin
                    if (!half_end)
                    begin
                        presc_cnt <= presc_cnt + 1'b1;
                    end
                    else
                    begin
                        presc_cnt <= '0;
                        sck_lvl   <= ~sck_lvl;
                        edge_cnt  <= edge_cnt + 1'b1;
                        if (drive_edge)
                        begin
                            mosi_q <= lead_bit(shift_out, lsb_q);
                        end
                        if (last_edge)
                        begin
                            state    <= SPI_IDLE;
                            rx_done  <= 1'b1;
                            edge_cnt <= '0;
                            // Keep ss low when the next word is already waiting
                            if (!tx_valid)
                            begin
                                ss <= 1'b1;
                            end
                        end
                    end
                end
                default:
                begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Shift registers
    //////////////////////////////

    always_ff @(posedge wr)
    begin
        if (tx_take)
        begin
            presc_q <= tx_presc;
            lsb_q   <= tx_lsb_first;
            // First bit already on mosi for CPHA 0
            shift_out <= tx_mode[0] ? tx_word : shift_word(tx_word, tx_lsb_first);
        end
        else
        begin
            if (drive_edge)
            begin
                shift_out <= shift_word(shift_out, lsb_q);
            end
            if (sample_edge)
            begin
                if (lsb_q)
                begin
                    shift_in <= {miso, shift_in[SPI_WORD_LEN-1:1]};
                end
                else
                begin
                    shift_in <= {shift_in[SPI_WORD_LEN-2:0], miso};
                end
            end
        end
    end

    // Complete word is in place while rx_done is high
    assign rx_word = shift_in;

    // CPOL inverts the clock, mosi idles high
    assign sck  = sck_lvl ^ mode_q[1];
    assign mosi = ss ? 1'b1 : mosi_q;

endmodule

`default_nettype wire

//--- source/spi_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host_port #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    wr,
    input  logic                    rst,
    input  logic                    send,
    input  spi_pkg::chan_idx_t      chan_sel,
    input  spi_pkg::spi_word_t      wdata,
    input  spi_pkg::presc_t         prescaler,
    input  spi_pkg::spi_mode_t      mode,
    input  logic                    lsb_first,
    input  logic                    clear_senderr,
    input  logic [NUM_CHANNELS-1:0] tx_take,
    output logic [NUM_CHANNELS-1:0] tx_valid,
    output spi_pkg::spi_word_t      tx_word [NUM_CHANNELS],
    output spi_pkg::presc_t         tx_presc [NUM_CHANNELS],
    output spi_pkg::spi_mode_t      tx_mode [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0] tx_lsb_first,
    output logic [NUM_CHANNELS-1:0] buff_empty,
    output logic                    send_err
);
    import spi_pkg::*;

    // One-hot decode of chan_sel, all zero for an index past the array
    logic [NUM_CHANNELS-1:0] sel_hit;
    // Buffer full flags, one per channel
    logic [NUM_CHANNELS-1:0] buf_full;
    // Write accepted into a buffer this cycle
    logic [NUM_CHANNELS-1:0] accept;
    // Send that has to be dropped
    logic                    bad_send;

    //////////////////////////////
    // Write decode
    //////////////////////////////

    always_comb
    begin
        sel_hit = '0;
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            // Compare against the index width of the select bus
            sel_hit[i] = (chan_sel == chan_idx_t'(i));
        end
    end

    // Only an empty buffer takes a word
    assign accept = send ? (sel_hit & ~buf_full) : '0;

    // Full target buffer or a channel that does not exist
    assign bad_send = send && (((sel_hit & buf_full) != '0) || (sel_hit == '0));

    //////////////////////////////
    // Buffer flags
    //////////////////////////////

    // Set by an accepted send, cleared when the channel takes the word
    // Both cannot hit the same channel in one cycle since take needs a full buffer
    always_ff @(posedge wr or posedge rst)
    begin
        if (rst)
        begin
            buf_full <= '0;
        end
        else
        begin
            buf_full <= (buf_full & ~tx_take) | accept;
        end
    end

    assign tx_valid   = buf_full;
    assign buff_empty = ~buf_full;

    //////////////////////////////
    // Buffer contents
    //////////////////////////////

    // Word and its settings are latched together
    always_ff @(posedge wr)
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (accept[i])
            begin
                tx_word[i]      <= wdata;
                tx_presc[i]     <= prescaler;
                tx_mode[i]      <= mode;
                tx_lsb_first[i] <= lsb_first;
            end
        end
    end

    //////////////////////////////
    // Send error
    //////////////////////////////

    // Sticky until cleared
    // A new error in the clear cycle is kept so it is not lost
    always_ff @(posedge wr or posedge rst)
    begin
        if (rst)
        begin
            send_err <= 1'b0;
        end
        else if (bad_send)
        begin
            send_err <= 1'b1;
        end
        else if (clear_senderr)
        begin
            send_err <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/spi_rx_collector.sv
`timescale 1ns/1ps
`default_nettype none

module spi_rx_collector #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    wr,
    input  logic                    rst,
    input  logic [NUM_CHANNELS-1:0] rx_done,
    input  spi_pkg::spi_word_t      rx_word [NUM_CHANNELS],
    input  logic                    rd,
    input  spi_pkg::chan_idx_t      rd_sel,
    output spi_pkg::spi_word_t      rdata,
    output logic [NUM_CHANNELS-1:0] char_received
);
    import spi_pkg::*;

    // Last received word per channel
    spi_word_t               rx_buf [NUM_CHANNELS];
    // Channel addressed by the current read
    logic [NUM_CHANNELS-1:0] rd_hit;

    //////////////////////////////
    // Read decode
    //////////////////////////////

    always_comb
    begin
        rd_hit = '0;
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            rd_hit[i] = rd && (rd_sel == chan_idx_t'(i));
        end
    end

    //////////////////////////////
    // Receive buffers
    //////////////////////////////

    // An unread word is simply overwritten
    always_ff @(posedge wr)
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (rx_done[i])
            begin
                rx_buf[i] <= rx_word[i];
            end
        end
    end

    // Flag set by rx_done, cleared by a read of that channel
    // rx_done wins when both land in the same cycle
    always_ff @(posedge wr or posedge rst)
    begin
        if (rst)
        begin
            char_received <= '0;
        end
        else
        begin
            char_received <= (char_received & ~rd_hit) | rx_done;
        end
    end

    //////////////////////////////
    // Read mux
    //////////////////////////////

    // Zero while rd is low or for a channel past the array
    always_comb
    begin
        rdata = '0;
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (rd_hit[i])
            begin
                rdata = rx_buf[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/spi_master_array.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_array #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    wr,
    input  logic                    rst,
    input  logic                    send,
    input  spi_pkg::chan_idx_t      chan_sel,
    input  spi_pkg::spi_word_t      wdata,
    input  spi_pkg::presc_t         prescaler,
    input  spi_pkg::spi_mode_t      mode,
    input  logic                    lsb_first,
    input  logic                    clear_senderr,
    input  logic                    rd,
    input  spi_pkg::chan_idx_t      rd_sel,
    input  logic [NUM_CHANNELS-1:0] miso,
    output spi_pkg::spi_word_t      rdata,
    output logic [NUM_CHANNELS-1:0] buff_empty,
    output logic [NUM_CHANNELS-1:0] char_received,
    output logic                    send_err,
    output logic [NUM_CHANNELS-1:0] sck,
    output logic [NUM_CHANNELS-1:0] mosi,
    output logic [NUM_CHANNELS-1:0] ss
);
    import spi_pkg::*;

    // Host port to channels
    logic [NUM_CHANNELS-1:0] tx_valid;
    logic [NUM_CHANNELS-1:0] tx_take;
    logic [NUM_CHANNELS-1:0] tx_lsb_first;
    spi_word_t               tx_word [NUM_CHANNELS];
    presc_t                  tx_presc [NUM_CHANNELS];
    spi_mode_t               tx_mode [NUM_CHANNELS];

    // Channels to collector
    logic [NUM_CHANNELS-1:0] rx_done;
    spi_word_t               rx_word [NUM_CHANNELS];

    //////////////////////////////
    // Host write side
    //////////////////////////////

    spi_host_port #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_host_port (
        .wr            (wr),
        .rst           (rst),
        .send          (send),
        .chan_sel      (chan_sel),
        .wdata         (wdata),
        .prescaler     (prescaler),
        .mode          (mode),
        .lsb_first     (lsb_first),
        .clear_senderr (clear_senderr),
        .tx_take       (tx_take),
        .tx_valid      (tx_valid),
        .tx_word       (tx_word),
        .tx_presc      (tx_presc),
        .tx_mode       (tx_mode),
        .tx_lsb_first  (tx_lsb_first),
        .buff_empty    (buff_empty),
        .send_err      (send_err)
    );

    //////////////////////////////
    // SPI engines
    //////////////////////////////

    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : gen_chan
        spi_channel u_chan (
            .wr           (wr),
            .rst          (rst),
            .tx_valid     (tx_valid[i]),
            .tx_word      (tx_word[i]),
            .tx_presc     (tx_presc[i]),
            .tx_mode      (tx_mode[i]),
            .tx_lsb_first (tx_lsb_first[i]),
            .miso         (miso[i]),
            .tx_take      (tx_take[i]),
            .rx_done      (rx_done[i]),
            .rx_word      (rx_word[i]),
            .sck          (sck[i]),
            .mosi         (mosi[i]),
            .ss           (ss[i])
        );
    end

    //////////////////////////////
    // Host read side
    //////////////////////////////

    spi_rx_collector #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_rx_collector (
        .wr            (wr),
        .rst           (rst),
        .rx_done       (rx_done),
        .rx_word       (rx_word),
        .rd            (rd),
        .rd_sel        (rd_sel),
        .rdata         (rdata),
        .char_received (char_received)
    );

endmodule

`default_nettype wire

//--- verification/spi_master_array_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_array_assertions #(
    parameter int NUM_CHANNELS = 4
) (
    input logic                    wr,
    input logic                    rst,
    input logic [NUM_CHANNELS-1:0] ss,
    input logic [NUM_CHANNELS-1:0] sck,
    input logic [NUM_CHANNELS-1:0] mosi,
    input logic [NUM_CHANNELS-1:0] tx_take,
    input logic [NUM_CHANNELS-1:0] tx_valid,
    input logic [NUM_CHANNELS-1:0] buff_empty
);

    // Failure counts per property
    int unsigned sck_fails   = 0;
    int unsigned mosi_fails  = 0;
    int unsigned take_fails  = 0;
    int unsigned reset_fails = 0;
    int unsigned fail_count;

    assign fail_count = sck_fails + mosi_fails + take_fails + reset_fails;

    //////////////////////////////
    // Pin checks, all channels at once
    //////////////////////////////

    // sck holds its idle level while the slave is deselected
    sck_idle: assert property (@(posedge wr) disable iff (rst)
        ((ss & $past(ss) & (sck ^ $past(sck))) == '0))
    else
    begin
        $error("sck toggled while ss was high");
        sck_fails++;
    end

    mosi_idle: assert property (@(posedge wr) disable iff (rst) ((ss & ~mosi) == '0))
    else
    begin
        $error("mosi low while ss was high");
        mosi_fails++;
    end

    //////////////////////////////
    // Buffer handshake
    //////////////////////////////

    // A take lasts one cycle and only happens with a full buffer
    take_valid: assert property (@(posedge wr) disable iff (rst)
        (((tx_take & ~tx_valid) | (tx_take & $past(tx_take))) == '0))
    else
    begin
        $error("tx_take pulsed with an empty buffer or for more than one cycle");
        take_fails++;
    end

    // All buffers empty coming out of reset
    reset_empty: assert property (@(posedge wr) $fell(rst) |-> (buff_empty == '1))
    else
    begin
        $error("buff_empty not all ones after reset");
        reset_fails++;
    end

endmodule

bind spi_master_array spi_master_array_assertions #(
    .NUM_CHANNELS (NUM_CHANNELS)
) u_assertions (
    .wr         (wr),
    .rst        (rst),
    .ss         (ss),
    .sck        (sck),
    .mosi       (mosi),
    .tx_take    (tx_take),
    .tx_valid   (tx_valid),
    .buff_empty (buff_empty)
);

`default_nettype wire

//--- verification/spi_master_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_array_tb;
    import spi_pkg::*;

    localparam int    NUM_CH         = 4;
    localparam int    CLK_PERIOD     = 4;
    localparam int    RST_CYCLES     = 3;
    localparam int    SEED           = 96204;
    // Longest word is 16 half periods of 256 cycles, plus handshake slack
    localparam int    CYCLES_PER_VEC = 16 * 256 + 20;
    localparam string VEC_FILE       = "verification/spi_master_vectors.txt";

    // Opcodes of the vector file
    localparam int OP_SEND     = 0;
    localparam int OP_B2B      = 1;
    localparam int OP_OVERFLOW = 2;
    localparam int OP_CLEAR    = 3;
    localparam int OP_LOAD     = 4;
    localparam int OP_READ     = 5;

    logic              wr = 1'b0;
    logic              rst;
    logic              send;
    chan_idx_t         chan_sel;
    spi_word_t         wdata;
    presc_t            prescaler;
    spi_mode_t         mode;
    logic              lsb_first;
    logic              clear_senderr;
    logic              rd;
    chan_idx_t         rd_sel;
    spi_word_t         rdata;
    logic [NUM_CH-1:0] buff_empty;
    logic [NUM_CH-1:0] char_received;
    logic              send_err;
    logic [NUM_CH-1:0] sck;
    logic [NUM_CH-1:0] mosi;
    logic [NUM_CH-1:0] ss;

    // Vector columns
    int v_op [$];
    int v_ch [$];
    int v_mode [$];
    int v_lsb [$];
    int v_presc [$];
    int v_wa [$];
    int v_wb [$];
    int v_wc [$];
    int v_exp [$];

    int errors      = 0;
    int passed      = 0;
    int failed      = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    int assert_fails;
    int errors_before;

    // ss activity per channel
    int low_cnt [NUM_CH];
    int last_low [NUM_CH];
    int rise_cnt [NUM_CH];
    int presc_of [NUM_CH];

    // Loopback, every channel hears its own mosi
    spi_master_array #(
        .NUM_CHANNELS (NUM_CH)
    ) dut (
        .wr            (wr),
        .rst           (rst),
        .send          (send),
        .chan_sel      (chan_sel),
        .wdata         (wdata),
        .prescaler     (prescaler),
        .mode          (mode),
        .lsb_first     (lsb_first),
        .clear_senderr (clear_senderr),
        .rd            (rd),
        .rd_sel        (rd_sel),
        .miso          (mosi),
        .rdata         (rdata),
        .buff_empty    (buff_empty),
        .char_received (char_received),
        .send_err      (send_err),
        .sck           (sck),
        .mosi          (mosi),
        .ss            (ss)
    );

    always #(CLK_PERIOD / 2) wr = ~wr;

    //////////////////////////////
    // Monitors
    //////////////////////////////

    // Length of the last ss low window and count of ss rising edges
    always @(negedge wr)
    begin
        for (int i = 0; i < NUM_CH; i++)
        begin
            if (rst)
            begin
                low_cnt[i]  <= 0;
                last_low[i] <= 0;
                rise_cnt[i] <= 0;
            end
            else if (!ss[i])
            begin
                low_cnt[i] <= low_cnt[i] + 1;
            end
            else if (low_cnt[i] != 0)
            begin
                last_low[i] <= low_cnt[i];
                low_cnt[i]  <= 0;
                rise_cnt[i] <= rise_cnt[i] + 1;
            end
        end
    end

    // Run limit from the number of vectors
    always @(posedge wr)
    begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Checks and helpers
    //////////////////////////////

    task automatic compare_value(input string name, input int got, input int exp);
        assert (got == exp)
        else
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    function automatic string op_name(input int op);
        case (op)
            OP_SEND:     return "send";
            OP_B2B:      return "back-to-back";
            OP_OVERFLOW: return "overflow";
            OP_CLEAR:    return "clear";
            OP_LOAD:     return "load";
            OP_READ:     return "read";
            default:     return "unknown";
        endcase
    endfunction

    // Comment and blank lines fail the scan and are skipped
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        int    op;
        int    ch;
        int    md;
        int    lb;
        int    ps;
        int    wa;
        int    wb;
        int    wc;
        int    ex;
        fd = $fopen(VEC_FILE, "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            op, ch, md, lb, ps, wa, wb, wc, ex);
                if (n == 9)
                begin
                    v_op.push_back(op);
                    v_ch.push_back(ch);
                    v_mode.push_back(md);
                    v_lsb.push_back(lb);
                    v_presc.push_back(ps);
                    v_wa.push_back(wa);
                    v_wb.push_back(wb);
                    v_wc.push_back(wc);
                    v_exp.push_back(ex);
                end
            end
            $fclose(fd);
        end
    endtask

    // One send strobe, returns on the edge that samples it
    task automatic send_word(input int ch, input int w, input int md, input int lb, input int ps);
        @(posedge wr);
        send      <= 1'b1;
        chan_sel  <= chan_idx_t'(ch);
        wdata     <= spi_word_t'(w);
        mode      <= spi_mode_t'(md);
        lsb_first <= lb[0];
        prescaler <= presc_t'(ps);
        @(posedge wr);
        send <= 1'b0;
    endtask

    // Buffer drained into the channel
    task automatic wait_taken(input int ch);
        do @(negedge wr); while (!buff_empty[ch]);
    endtask

    task automatic wait_received(input int ch);
        do @(negedge wr); while (!char_received[ch]);
    endtask

    // One-cycle read, returns after the flag has been cleared
    task automatic read_word(input int ch, output int data);
        @(posedge wr);
        rd     <= 1'b1;
        rd_sel <= chan_idx_t'(ch);
        @(negedge wr);
        data = int'(rdata);
        @(posedge wr);
        rd <= 1'b0;
        @(negedge wr);
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge wr);
    endtask

    //////////////////////////////
    // Vector execution
    //////////////////////////////

    task automatic run_vector(input int op, input int ch, input int md, input int lb,
                              input int ps, input int wa, input int wb, input int wc,
                              input int ex);
        int                data;
        int                rises;
        int                min_low;
        logic [NUM_CH-1:0] flags_before;
        @(negedge wr);
        rises   = rise_cnt[ch];
        // 2 x word length half periods of 2**(p+1) cycles each
        min_low = 2 * SPI_WORD_LEN * (2 << ps);
        case (op)
            OP_SEND:
            begin
                send_word(ch, wa, md, lb, ps);
                wait_received(ch);
                read_word(ch, data);
                compare_value("rdata", data, ex);
                compare_value("send_err", int'(send_err), 0);
                require(last_low[ch] >= min_low, "ss low time shorter than the prescaler minimum");
                require(rise_cnt[ch] - rises == 1, "ss did not return high exactly once");
            end
            OP_B2B:
            begin
                send_word(ch, wa, md, lb, ps);
                wait_taken(ch);
                // Second word lands while the first one shifts
                send_word(ch, wb, md, lb, ps);
                wait_received(ch);
                read_word(ch, data);
                compare_value("rdata", data, wa);
                wait_received(ch);
                read_word(ch, data);
                compare_value("rdata", data, ex);
                compare_value("send_err", int'(send_err), 0);
                require(last_low[ch] >= 2 * min_low, "ss low time too short for two words");
                require(rise_cnt[ch] - rises == 1, "ss went high between back-to-back words");
            end
            OP_OVERFLOW:
            begin
                send_word(ch, wa, md, lb, ps);
                wait_taken(ch);
                send_word(ch, wb, md, lb, ps);
                // Buffer is full here, this one is dropped
                send_word(ch, wc, md, lb, ps);
                @(negedge wr);
                compare_value("send_err", int'(send_err), 1);
                // Second word still waits in the buffer
                compare_value("buff_empty", int'(buff_empty[ch]), 0);
                wait_received(ch);
                read_word(ch, data);
                compare_value("rdata", data, wa);
                require(data != wc, "dropped word showed up on rdata");
                wait_received(ch);
                read_word(ch, data);
                compare_value("rdata", data, ex);
                require(data != wc, "dropped word showed up on rdata");
                compare_value("send_err", int'(send_err), 1);
            end
            OP_CLEAR:
            begin
                require(send_err, "send_err was not set before the clear");
                @(posedge wr);
                clear_senderr <= 1'b1;
                @(posedge wr);
                clear_senderr <= 1'b0;
                @(negedge wr);
                compare_value("send_err", int'(send_err), ex);
            end
            OP_LOAD:
            begin
                send_word(ch, wa, md, lb, ps);
                presc_of[ch] = ps;
                @(negedge wr);
                compare_value("send_err", int'(send_err), 0);
                // Buffer reads full one cycle after the send
                compare_value("buff_empty", int'(buff_empty[ch]), 0);
            end
            OP_READ:
            begin
                wait_received(ch);
                flags_before = char_received;
                compare_value("rdata", int'(rdata), 0);
                read_word(ch, data);
                compare_value("rdata", data, ex);
                // Flags that were set stay set, except the one just read
                compare_value("char_received", int'(char_received & flags_before),
                              int'(flags_before & ~(NUM_CH'(1) << ch)));
                require(last_low[ch] >= 2 * SPI_WORD_LEN * (2 << presc_of[ch]),
                        "ss low time shorter than the prescaler minimum");
            end
            default:
            begin
                require(1'b0, "unknown opcode in the vector file");
            end
        endcase
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        rst           = 1'b1;
        send          = 1'b0;
        chan_sel      = '0;
        wdata         = '0;
        prescaler     = '0;
        mode          = '0;
        lsb_first     = 1'b0;
        clear_senderr = 1'b0;
        rd            = 1'b0;
        rd_sel        = '0;
        void'($urandom(SEED));
        load_vectors();
        if (v_op.size() == 0)
        begin
            $display("No vectors could be read from %s", VEC_FILE);
            $display("STATUS: FAIL");
            $finish;
        end
        else
        begin
            cycle_limit = v_op.size() * CYCLES_PER_VEC;
            repeat (RST_CYCLES) @(posedge wr);
            rst <= 1'b0;
            @(posedge wr);
            for (int i = 0; i < v_op.size(); i++)
            begin
                errors_before = errors;
                run_vector(v_op[i], v_ch[i], v_mode[i], v_lsb[i], v_presc[i],
                           v_wa[i], v_wb[i], v_wc[i], v_exp[i]);
                if (errors == errors_before)
                begin
                    passed++;
                    $display("Test %0d (%s, channel %0d): passed", i, op_name(v_op[i]), v_ch[i]);
                end
                else
                begin
                    failed++;
                    $display("Test %0d (%s, channel %0d): failed", i, op_name(v_op[i]), v_ch[i]);
                end
                idle_gap();
            end
            // Failures of the bound pin checks count as errors too
            assert_fails = int'(dut.u_assertions.fail_count);
            errors += assert_fails;
            $display("Tests: %0d run, %0d passed, %0d failed; errors %0d, assertion failures %0d",
                     v_op.size(), passed, failed, errors, assert_fails);
            if (errors == 0)
            begin
                $display("STATUS: PASS");
            end
            else
            begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/spi_master_vectors.txt
# Columns in hex: op ch mode lsb_first prescaler word_a word_b word_c expected
# op 0 send, 1 back-to-back, 2 overflow, 3 clear, 4 load only, 5 wait and read
0 0 0 0 0 a5 00 00 a5
0 1 1 0 0 3c 00 00 3c
0 2 2 0 1 81 00 00 81
0 3 3 0 0 c6 00 00 c6
0 0 0 1 0 5a 00 00 5a
0 1 1 1 2 e7 00 00 e7
0 2 2 1 0 01 00 00 01
0 3 3 1 1 fe 00 00 fe
0 0 1 0 3 96 00 00 96
0 1 2 1 7 e1 00 00 e1
1 2 1 0 1 12 34 00 34
2 3 2 1 0 55 aa 0f aa
3 0 0 0 0 00 00 00 00
4 0 0 0 0 11 00 00 00
4 1 3 1 1 22 00 00 00
4 2 1 0 2 33 00 00 00
4 3 2 1 0 44 00 00 00
5 2 0 0 0 00 00 00 33
5 0 0 0 0 00 00 00 11
5 3 0 0 0 00 00 00 44
5 1 0 0 0 00 00 00 22

//--- filelist.f
source/spi_pkg.sv
source/spi_channel.sv
source/spi_host_port.sv
source/spi_rx_collector.sv
source/spi_master_array.sv
verification/spi_master_array_assertions.sv
verification/spi_master_array_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SPI master array testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
BIN=spi_master_array_sim

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module spi_master_array_tb \
    -Mdir obj_dir -o "$BIN"

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/"$BIN" +verilator+error+limit+1000 | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
